// File: iq_cfg.svh
`ifndef IQ_CFG_SVH
`define IQ_CFG_SVH

// ----------------------------------------------------------------------
// Issue queue build parameters
// ----------------------------------------------------------------------

// Log2 of the reorder buffer size
// A robid carries one extra wrap bit on top of this index
`define ROB_SIZE_LOG 6

// Number of issue queue slots, need not be a power of two
`define IQ_DEPTH 8

// Condition bits per instruction, one per source operand
`define COND_WIDTH 2

`endif

// File: rob_pkg.sv
`include "iq_cfg.svh"

package rob_pkg;

    // Plain index into the reorder buffer
    typedef logic [`ROB_SIZE_LOG-1:0] rob_idx_t;

    // Robid with the wrap bit on top of the index
    typedef struct packed {
        logic     wrap;
        rob_idx_t idx;
    } robid_t;

    // Broadcast flush point, everything younger than robid dies
    typedef struct packed {
        logic   valid;
        robid_t robid;
    } rob_flush_t;

    // True when a was allocated after b
    // Same lap compares index directly, different lap inverts it
    function automatic logic rob_is_younger(input robid_t a, input robid_t b);
        if (a.wrap == b.wrap) begin
            return a.idx > b.idx;
        end
        return a.idx < b.idx;
    endfunction

endpackage

// File: iq_pkg.sv
`include "iq_cfg.svh"

package iq_pkg;

    // ------------------------------------------------------------------
    // Functional unit encodings carried in the payload
    // ------------------------------------------------------------------
    localparam logic [3:0] FU_ALU = 4'd0;
    localparam logic [3:0] FU_MUL = 4'd1;
    localparam logic [3:0] FU_DIV = 4'd2;
    localparam logic [3:0] FU_LSU = 4'd3;
    localparam logic [3:0] FU_BRU = 4'd4;

    // ------------------------------------------------------------------
    // Instruction payload, the queue never looks inside
    // ------------------------------------------------------------------
    typedef struct packed {
        // Fetch address
        logic [31:0] pc;
        // Raw instruction word
        logic [31:0] insn;
        // Destination physical register
        logic [5:0]  prd;
        // Target execution unit
        logic [3:0]  fu_type;
    } iq_payload_t;

    // ------------------------------------------------------------------
    // Condition update broadcast, addressed by robid
    // ------------------------------------------------------------------
    typedef struct packed {
        logic                   valid;
        rob_pkg::robid_t        robid;
        // Bits to touch
        logic [`COND_WIDTH-1:0] mask;
        // New values where mask is set
        logic [`COND_WIDTH-1:0] value;
    } iq_update_t;

endpackage

// File: iq_entry.sv
`timescale 1ns/1ps
`include "iq_cfg.svh"

module iq_entry #(
    parameter type payload_t = logic
) (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   write,
    input  logic                   clear,
    input  rob_pkg::robid_t        robid_in,
    input  logic [`COND_WIDTH-1:0] cond_in,
    input  payload_t               payload_in,
    input  iq_pkg::iq_update_t     update,
    output logic                   valid,
    output logic                   ready,
    output rob_pkg::robid_t        robid,
    output logic [`COND_WIDTH-1:0] cond,
    output payload_t               payload
);

    // Update hits the resident instruction
    logic hit_held;
    // Update hits the instruction being written this cycle
    logic hit_in;

    assign hit_held = update.valid && valid && (update.robid == robid);
    assign hit_in   = update.valid && (update.robid == robid_in);

    // Occupancy flag, clear wins over write
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid <= 1'b0;
        end else if (clear) begin
            valid <= 1'b0;
        end else if (write) begin
            valid <= 1'b1;
        end
    end

    // Condition bits
    // A write merges any update for the same robid in that cycle
    always_ff @(posedge clock) begin
        if (write && !clear) begin
            if (hit_in) begin
                cond <= (cond_in & ~update.mask) | (update.value & update.mask);
            end else begin
                cond <= cond_in;
            end
        end else if (hit_held) begin
            cond <= (cond & ~update.mask) | (update.value & update.mask);
        end
    end

    // Robid and payload only change on write
    always_ff @(posedge clock) begin
        if (write) begin
            robid   <= robid_in;
            payload <= payload_in;
        end
    end

    // Eligible once every source operand is available
    assign ready = valid && (&cond);

endmodule

// File: age_buffer.sv
`timescale 1ns/1ps
`include "iq_cfg.svh"

module age_buffer #(
    parameter int  DEPTH     = `IQ_DEPTH,
    parameter type payload_t = logic
) (
    input  logic                   clock,
    input  logic                   reset_n,

    // Enqueue side
    input  logic                   enq_valid,
    input  rob_pkg::robid_t        enq_robid,
    input  logic [`COND_WIDTH-1:0] enq_cond,
    input  payload_t               enq_payload,
    output logic                   enq_ready,

    // Dequeue side
    output logic                   deq_valid,
    output rob_pkg::robid_t        deq_robid,
    output payload_t               deq_payload,
    input  logic                   deq_ready,

    // Broadcasts
    input  iq_pkg::iq_update_t     update,
    input  rob_pkg::rob_flush_t    flush
);

    import rob_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // ------------------------------------------------------------------
    // Slot array
    // ------------------------------------------------------------------
    logic [DEPTH-1:0] slot_write;
    logic [DEPTH-1:0] slot_clear;
    logic [DEPTH-1:0] slot_valid;
    logic [DEPTH-1:0] slot_ready;
    robid_t           slot_robid   [DEPTH];
    payload_t         slot_payload [DEPTH];

    // Row i column j set means slot i is older than slot j
    logic [DEPTH-1:0][DEPTH-1:0] age_matrix;
    // Transposed view, age_col[i][j] set when j is older than i
    logic [DEPTH-1:0][DEPTH-1:0] age_col;

    logic [DEPTH-1:0] oldest_vec;
    logic [DEPTH-1:0] flush_vec;

    logic             free_found;
    logic [IDX_W-1:0] free_idx;
    logic             sel_found;
    logic [IDX_W-1:0] sel_idx;
    logic             enq_fire;
    logic             deq_fire;

    for (genvar g = 0; g < DEPTH; g++) begin : gen_slot
        // Condition bits stay internal, ready already folds them in
        iq_entry #(
            .payload_t (payload_t)
        ) u_entry (
            .clock      (clock),
            .reset_n    (reset_n),
            .write      (slot_write[g]),
            .clear      (slot_clear[g]),
            .robid_in   (enq_robid),
            .cond_in    (enq_cond),
            .payload_in (enq_payload),
            .update     (update),
            .valid      (slot_valid[g]),
            .ready      (slot_ready[g]),
            .robid      (slot_robid[g]),
            .cond       (),
            .payload    (slot_payload[g])
        );
    end

    // ------------------------------------------------------------------
    // Free slot search, lowest index wins
    // ------------------------------------------------------------------
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_found = 1'b1;
                free_idx   = IDX_W'(i);
            end
        end
    end

    // ------------------------------------------------------------------
    // Oldest ready select
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            for (int j = 0; j < DEPTH; j++) begin
                age_col[i][j] = age_matrix[j][i];
            end
            // Ready and no older ready slot competing
            oldest_vec[i] = slot_ready[i] && !(|(age_col[i] & slot_ready));
        end
    end

    // Age order makes oldest_vec one-hot, encoder is only a formality
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (oldest_vec[i]) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    // ------------------------------------------------------------------
    // Flush decode
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            flush_vec[i] = flush.valid && slot_valid[i]
                           && rob_is_younger(slot_robid[i], flush.robid);
        end
    end

    // Flush freezes both sides for one cycle
    assign enq_ready = free_found && !flush.valid;
    assign enq_fire  = enq_valid && enq_ready;
    assign deq_valid = sel_found;
    assign deq_fire  = sel_found && deq_ready && !flush.valid;

    assign deq_robid   = slot_robid[sel_idx];
    assign deq_payload = slot_payload[sel_idx];

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            slot_write[i] = enq_fire && (free_idx == IDX_W'(i));
            slot_clear[i] = flush_vec[i] || (deq_fire && (sel_idx == IDX_W'(i)));
        end
    end

    // ------------------------------------------------------------------
    // Age matrix maintenance
    // ------------------------------------------------------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            age_matrix <= '0;
        end else begin
            // Newcomer is younger than everything already held
            if (enq_fire) begin
                for (int j = 0; j < DEPTH; j++) begin
                    age_matrix[free_idx][j] <= 1'b0;
                    age_matrix[j][free_idx] <= slot_valid[j];
                end
            end
            // Leaving slots drop out of both row and column
            for (int i = 0; i < DEPTH; i++) begin
                if (slot_clear[i]) begin
                    for (int j = 0; j < DEPTH; j++) begin
                        age_matrix[i][j] <= 1'b0;
                        age_matrix[j][i] <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// File: issue_reg.sv
`timescale 1ns/1ps

module issue_reg #(
    parameter type payload_t = logic
) (
    input  logic                clock,
    input  logic                reset_n,

    // From the buffer
    input  logic                in_valid,
    input  rob_pkg::robid_t     in_robid,
    input  payload_t            in_payload,
    output logic                in_ready,

    // Toward the execution port
    output logic                issue_valid,
    output rob_pkg::robid_t     issue_robid,
    output payload_t            issue_payload,
    input  logic                issue_ready,

    input  rob_pkg::rob_flush_t flush
);

    import rob_pkg::*;

    logic   held_valid;
    robid_t held_robid;
    logic   load;
    logic   kill;

    // Held instruction lies past the flush point
    assign kill = flush.valid && held_valid && rob_is_younger(held_robid, flush.robid);

    // Empty or draining this cycle, never during flush
    assign in_ready = (!held_valid || issue_ready) && !flush.valid;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            held_valid <= 1'b0;
        end else if (kill) begin
            held_valid <= 1'b0;
        end else if (load) begin
            held_valid <= 1'b1;
        end else if (issue_ready) begin
            held_valid <= 1'b0;
        end
    end

    // Contents change only on load, so they hold under back-pressure
    always_ff @(posedge clock) begin
        if (load) begin
            held_robid    <= in_robid;
            issue_payload <= in_payload;
        end
    end

    // A killed instruction is never offered to execution
    assign issue_valid = held_valid && !kill;
    assign issue_robid = held_robid;

endmodule

// File: issue_queue.sv
`timescale 1ns/1ps
`include "iq_cfg.svh"

module issue_queue (
    input  logic                   clock,
    input  logic                   reset_n,

    // Dispatch
    input  logic                   disp_valid,
    input  rob_pkg::robid_t        disp_robid,
    input  logic [`COND_WIDTH-1:0] disp_cond,
    input  iq_pkg::iq_payload_t    disp_payload,
    output logic                   disp_ready,

    // Broadcasts
    input  iq_pkg::iq_update_t     update,
    input  rob_pkg::rob_flush_t    flush,

    // Issue
    output logic                   issue_valid,
    output rob_pkg::robid_t        issue_robid,
    output iq_pkg::iq_payload_t    issue_payload,
    input  logic                   issue_ready
);

    import rob_pkg::*;
    import iq_pkg::*;

    // ------------------------------------------------------------------
    // Buffer to issue register
    // ------------------------------------------------------------------
    logic        deq_valid;
    logic        deq_ready;
    robid_t      deq_robid;
    iq_payload_t deq_payload;

    age_buffer #(
        .DEPTH     (`IQ_DEPTH),
        .payload_t (iq_payload_t)
    ) u_age_buffer (
        .clock       (clock),
        .reset_n     (reset_n),
        .enq_valid   (disp_valid),
        .enq_robid   (disp_robid),
        .enq_cond    (disp_cond),
        .enq_payload (disp_payload),
        .enq_ready   (disp_ready),
        .deq_valid   (deq_valid),
        .deq_robid   (deq_robid),
        .deq_payload (deq_payload),
        .deq_ready   (deq_ready),
        .update      (update),
        .flush       (flush)
    );

    issue_reg #(
        .payload_t (iq_payload_t)
    ) u_issue_reg (
        .clock         (clock),
        .reset_n       (reset_n),
        .in_valid      (deq_valid),
        .in_robid      (deq_robid),
        .in_payload    (deq_payload),
        .in_ready      (deq_ready),
        .issue_valid   (issue_valid),
        .issue_robid   (issue_robid),
        .issue_payload (issue_payload),
        .issue_ready   (issue_ready),
        .flush         (flush)
    );

endmodule

// File: issue_queue_chk.sv
`timescale 1ns/1ps
`include "iq_cfg.svh"

module issue_queue_chk (
    input logic                   clock,
    input logic                   reset_n,
    input logic                   disp_valid,
    input rob_pkg::robid_t        disp_robid,
    input logic [`COND_WIDTH-1:0] disp_cond,
    input iq_pkg::iq_payload_t    disp_payload,
    input logic                   disp_ready,
    input iq_pkg::iq_update_t     update,
    input rob_pkg::rob_flush_t    flush,
    input logic                   issue_valid,
    input rob_pkg::robid_t        issue_robid,
    input iq_pkg::iq_payload_t    issue_payload,
    input logic                   issue_ready
);

    import rob_pkg::*;
    import iq_pkg::*;

    localparam int ROBS = 1 << `ROB_SIZE_LOG;

    // Count of failed assertions
    int error_count = 0;

    // ------------------------------------------------------------------
    // Shadow model indexed by robid index
    // ------------------------------------------------------------------
    logic [ROBS-1:0]        live;
    robid_t                 live_robid   [ROBS];
    logic [`COND_WIDTH-1:0] live_cond    [ROBS];
    iq_payload_t            live_payload [ROBS];

    // Ready history, one and two cycles back
    logic [ROBS-1:0] rdy_now;
    logic [ROBS-1:0] rdy_d1;
    logic [ROBS-1:0] rdy_d2;
    // Live robids older than the one on issue
    logic [ROBS-1:0] older_live;
    // Issue output was stalled last cycle
    logic            held_q;
    logic            fresh;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            live <= '0;
        end else begin
            // Flush first, then issue, then a new accept
            for (int i = 0; i < ROBS; i++) begin
                if (flush.valid && live[i] && rob_is_younger(live_robid[i], flush.robid)) begin
                    live[i] <= 1'b0;
                end
            end
            if (issue_valid && issue_ready) begin
                live[issue_robid.idx] <= 1'b0;
            end
            if (disp_valid && disp_ready) begin
                live[disp_robid.idx] <= 1'b1;
            end
        end
    end

    // Masked wakeups, an update in the accept cycle merges into the new bits
    always_ff @(posedge clock) begin
        for (int i = 0; i < ROBS; i++) begin
            if (update.valid && live[i] && live_robid[i] == update.robid) begin
                live_cond[i] <= (live_cond[i] & ~update.mask) | (update.value & update.mask);
            end
        end
        if (disp_valid && disp_ready) begin
            live_robid[disp_robid.idx]   <= disp_robid;
            live_payload[disp_robid.idx] <= disp_payload;
            if (update.valid && update.robid == disp_robid) begin
                live_cond[disp_robid.idx] <= (disp_cond & ~update.mask)
                                             | (update.value & update.mask);
            end else begin
                live_cond[disp_robid.idx] <= disp_cond;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ROBS; i++) begin
            rdy_now[i]    = live[i] && (&live_cond[i]);
            older_live[i] = live[i] && rob_is_younger(issue_robid, live_robid[i]);
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            held_q <= 1'b0;
            rdy_d1 <= '0;
            rdy_d2 <= '0;
        end else begin
            held_q <= issue_valid && !issue_ready;
            rdy_d1 <= rdy_now;
            rdy_d2 <= rdy_d1;
        end
    end

    // New instruction on issue, not one held over from a stall
    assign fresh = issue_valid && !held_q;

    // ------------------------------------------------------------------
    // Properties
    // ------------------------------------------------------------------
    a_reset: assert property (@(posedge clock) $rose(reset_n) |-> !issue_valid && disp_ready)
        else begin
            $error("ERROR %0t issue_valid %b disp_ready %b, expected 0 and 1 after reset",
                   $time, issue_valid, disp_ready);
            error_count++;
        end

    a_ready: assert property (@(posedge clock) disable iff (!reset_n)
        fresh |-> rdy_d1[issue_robid.idx] && live_robid[issue_robid.idx] == issue_robid)
        else begin
            $error("Robid %h issued without being live and ready", issue_robid);
            error_count++;
        end

    // Payload leaves with the robid it was dispatched with
    a_payload: assert property (@(posedge clock) disable iff (!reset_n)
        fresh |-> issue_payload == live_payload[issue_robid.idx])
        else begin
            $error("ERROR %0t issue_payload %h, expected %h",
                   $time, issue_payload, live_payload[issue_robid.idx]);
            error_count++;
        end

    a_age: assert property (@(posedge clock) disable iff (!reset_n)
        fresh |-> (older_live & rdy_d2) == '0)
        else begin
            $error("Robid %h issued ahead of an older ready instruction", issue_robid);
            error_count++;
        end

    // Flushed robids are no longer live, so they must not issue
    a_live: assert property (@(posedge clock) disable iff (!reset_n)
        issue_valid && issue_ready |->
            live[issue_robid.idx] && live_robid[issue_robid.idx] == issue_robid)
        else begin
            $error("Robid %h issued after being flushed or issued before", issue_robid);
            error_count++;
        end

    a_hold: assert property (@(posedge clock) disable iff (!reset_n)
        issue_valid && !issue_ready |=> $stable(issue_robid) && $stable(issue_payload)
            && (issue_valid || (flush.valid && rob_is_younger(issue_robid, flush.robid))))
        else begin
            $error("Issue output changed or dropped under back-pressure");
            error_count++;
        end

    a_full: assert property (@(posedge clock) disable iff (!reset_n)
        !flush.valid && !disp_ready |-> $countones(live) >= `IQ_DEPTH)
        else begin
            $error("ERROR %0t disp_ready %b with %0d in flight, expected 1",
                   $time, disp_ready, $countones(live));
            error_count++;
        end

    a_room: assert property (@(posedge clock) disable iff (!reset_n)
        $countones(live) > `IQ_DEPTH |-> !disp_ready)
        else begin
            $error("ERROR %0t disp_ready %b with %0d in flight, expected 0",
                   $time, disp_ready, $countones(live));
            error_count++;
        end

endmodule

bind issue_queue issue_queue_chk chk_i (
    .clock         (clock),
    .reset_n       (reset_n),
    .disp_valid    (disp_valid),
    .disp_robid    (disp_robid),
    .disp_cond     (disp_cond),
    .disp_payload  (disp_payload),
    .disp_ready    (disp_ready),
    .update        (update),
    .flush         (flush),
    .issue_valid   (issue_valid),
    .issue_robid   (issue_robid),
    .issue_payload (issue_payload),
    .issue_ready   (issue_ready)
);

// File: tb_issue_queue.sv
`timescale 1ns/1ps
`include "iq_cfg.svh"

module tb_issue_queue;

    import rob_pkg::*;
    import iq_pkg::*;

    localparam int HALF_PERIOD  = 10;
    localparam int FILL_CYCLES  = 12;
    localparam int WAKE_CYCLES  = 40;
    localparam int RAND_CYCLES  = 300;
    localparam int FLUSH_CYCLES = 300;
    localparam int TOTAL_CYCLES = 3 + FILL_CYCLES + WAKE_CYCLES + RAND_CYCLES + FLUSH_CYCLES + 2;
    // Live robid window, kept well under half the robid space
    localparam int MAX_WINDOW   = 28;

    logic                   clock;
    logic                   reset_n;
    logic                   disp_valid;
    robid_t                 disp_robid;
    logic [`COND_WIDTH-1:0] disp_cond;
    iq_payload_t            disp_payload;
    logic                   disp_ready;
    iq_update_t             update;
    rob_flush_t             flush;
    logic                   issue_valid;
    robid_t                 issue_robid;
    iq_payload_t            issue_payload;
    logic                   issue_ready;

    // Allocation state, queue kept oldest first
    robid_t      next_robid;
    robid_t      live_q [$];

    issue_queue dut_i (
        .clock         (clock),
        .reset_n       (reset_n),
        .disp_valid    (disp_valid),
        .disp_robid    (disp_robid),
        .disp_cond     (disp_cond),
        .disp_payload  (disp_payload),
        .disp_ready    (disp_ready),
        .update        (update),
        .flush         (flush),
        .issue_valid   (issue_valid),
        .issue_robid   (issue_robid),
        .issue_payload (issue_payload),
        .issue_ready   (issue_ready)
    );

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Watchdog
    initial begin
        #(TOTAL_CYCLES * 2 * HALF_PERIOD + 1000);
        $display("STATUS: FAIL");
        $fatal(1, "Timeout, stimulus did not finish within %0d cycles", TOTAL_CYCLES);
    end

    // Assertion failures end the run at the next falling edge
    always @(negedge clock) begin
        if (dut_i.chk_i.error_count != 0) begin
            $display("STATUS: FAIL");
            $fatal(1, "Checker reported %0d assertion failures", dut_i.chk_i.error_count);
        end
    end

    function automatic bit chance(input int pct);
        return int'($urandom % 100) < pct;
    endfunction

    function automatic iq_payload_t random_payload();
        iq_payload_t p;
        p.pc      = $urandom;
        p.insn    = $urandom;
        p.prd     = 6'($urandom);
        p.fu_type = 4'($urandom % 5);
        return p;
    endfunction

    // Drop the flush robid's younger neighbours, queue order is age order
    task automatic drop_younger(input robid_t point);
        int k;
        k = -1;
        foreach (live_q[i]) begin
            if (live_q[i] == point) begin
                k = i;
            end
        end
        while (k >= 0 && live_q.size() > k + 1) begin
            void'(live_q.pop_back());
        end
    endtask

    task automatic drop_issued(input robid_t rid);
        int k;
        k = -1;
        foreach (live_q[i]) begin
            if (live_q[i] == rid && k < 0) begin
                k = i;
            end
        end
        if (k >= 0) begin
            live_q.delete(k);
        end
    endtask

    // One cycle of stimulus, percentages pick what is driven
    task automatic run_cycle(input int disp_pct, input int ready_pct, input int update_pct,
                             input int flush_pct, input bit cond_random);
        iq_update_t upd;
        rob_flush_t fl;
        int         window;
        logic       accepted;
        logic       issued;
        @(negedge clock);
        upd    = '0;
        fl     = '0;
        window = (live_q.size() > 0) ? int'(7'(next_robid - live_q[0])) : 0;
        disp_valid   = chance(disp_pct) && (window < MAX_WINDOW);
        disp_robid   = next_robid;
        disp_cond    = cond_random ? `COND_WIDTH'($urandom) : '0;
        disp_payload = random_payload();
        if (live_q.size() > 0 && chance(update_pct)) begin
            upd.valid = 1'b1;
            upd.robid = live_q[$urandom % live_q.size()];
            upd.mask  = `COND_WIDTH'($urandom);
            // Wakeups only ever set bits
            upd.value = upd.mask;
        end
        if (live_q.size() > 0 && chance(flush_pct)) begin
            fl.valid = 1'b1;
            fl.robid = live_q[$urandom % live_q.size()];
        end
        update      = upd;
        flush       = fl;
        issue_ready = chance(ready_pct);
        // Handshakes settle well before the rising edge
        #(HALF_PERIOD / 2);
        accepted = disp_valid && disp_ready;
        issued   = issue_valid && issue_ready;
        if (fl.valid) begin
            drop_younger(fl.robid);
            next_robid = robid_t'(fl.robid + 7'd1);
        end
        if (issued) begin
            drop_issued(issue_robid);
        end
        if (accepted) begin
            live_q.push_back(next_robid);
            next_robid = robid_t'(next_robid + 7'd1);
        end
    endtask

    initial begin
        void'($urandom(32'h846669fe));
        reset_n      = 1'b0;
        disp_valid   = 1'b0;
        disp_robid   = '0;
        disp_cond    = '0;
        disp_payload = '0;
        update       = '0;
        flush        = '0;
        issue_ready  = 1'b0;
        next_robid   = '0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        // Fill with nothing ready and the port stalled
        repeat (FILL_CYCLES) run_cycle(100, 0, 0, 0, 1'b0);
        // Wake up by updates, first against a stalled port
        repeat (10) run_cycle(100, 0, 100, 0, 1'b0);
        repeat (WAKE_CYCLES - 10) run_cycle(0, 100, 100, 0, 1'b0);
        // Random traffic
        repeat (RAND_CYCLES) run_cycle(70, 60, 50, 0, 1'b1);
        // Random traffic with flushes
        repeat (FLUSH_CYCLES) run_cycle(70, 60, 50, 6, 1'b1);

        @(negedge clock);
        if (dut_i.chk_i.error_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "Checker reported %0d assertion failures", dut_i.chk_i.error_count);
        end
    end

endmodule

// File: list.f
+incdir+.
rob_pkg.sv
iq_pkg.sv
iq_entry.sv
age_buffer.sv
issue_reg.sv
issue_queue.sv
issue_queue_chk.sv
tb_issue_queue.sv

// File: run.sh
#!/bin/sh
# Compile and run the issue queue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_issue_queue -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

# Assertion errors must not stop the run before the testbench reports them
./obj_dir/Vtb_issue_queue +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
